// File: source/axi_burst_pkg.sv
`default_nettype none

package axi_burst_pkg;

  // address width of the AXI address channels and of the beat path
  localparam int addr_width_lp = 32;

  // data bus width in bits
  localparam int data_width_lp = 64;

  // byte lanes on the data bus
  localparam int mask_width_lp = data_width_lp / 8;

  // log2 of the lane count, bits of byte offset inside one word
  localparam int lg_mask_width_lp = $clog2(mask_width_lp);

  // memory word address drops the byte offset
  localparam int word_addr_width_lp = addr_width_lp - lg_mask_width_lp;

  // largest legal axsize, 2**3 = 8 bytes fills the bus
  localparam int max_size_lp = 3;

  // axburst encoding
  typedef enum logic [1:0] {
    e_fixed    = 2'd0,
    e_incr     = 2'd1,
    e_wrap     = 2'd2,
    e_reserved = 2'd3
  } axi_burst_e;

endpackage

`default_nettype wire

// File: source/axi_ax_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ax_arbiter (
  input  wire                                    clk_i
  , input  wire                                  reset_i

  // read address channel
  , input  wire                                  ar_v_i
  , output logic                                 ar_ready_and_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0] ar_addr_i
  , input  axi_burst_pkg::axi_burst_e             ar_burst_i
  , input  wire [7:0]                            ar_len_i
  , input  wire [2:0]                            ar_size_i

  // write address channel
  , input  wire                                  aw_v_i
  , output logic                                 aw_ready_and_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0] aw_addr_i
  , input  axi_burst_pkg::axi_burst_e             aw_burst_i
  , input  wire [7:0]                            aw_len_i
  , input  wire [2:0]                            aw_size_i

  // single request toward the pump
  , output logic                                 req_v_o
  , input  wire                                  req_ready_and_i
  , output logic [axi_burst_pkg::addr_width_lp-1:0] req_addr_o
  , output axi_burst_pkg::axi_burst_e             req_burst_o
  , output logic [7:0]                           req_len_o
  , output logic [2:0]                           req_size_o
  , output logic                                 req_write_o
  );

  import axi_burst_pkg::*;

  // round-robin pointer, 0 favours read, 1 favours write
  logic rr_r;
  logic grant_ar, grant_aw;
  logic accept;

  // read wins if alone or if the pointer sits on read
  assign grant_ar = ar_v_i & (~aw_v_i | ~rr_r);
  // write wins if alone or if the pointer sits on write
  assign grant_aw = aw_v_i & (~ar_v_i | rr_r);

  assign req_v_o     = ar_v_i | aw_v_i;
  assign req_write_o = grant_aw;

  // fields of the winning channel, read side when nothing is granted
  assign req_addr_o  = grant_aw ? aw_addr_i  : ar_addr_i;
  assign req_burst_o = grant_aw ? aw_burst_i : ar_burst_i;
  assign req_len_o   = grant_aw ? aw_len_i   : ar_len_i;
  assign req_size_o  = grant_aw ? aw_size_i  : ar_size_i;

  // pump ready only reaches the granted channel
  assign ar_ready_and_o = grant_ar & req_ready_and_i;
  assign aw_ready_and_o = grant_aw & req_ready_and_i;

  assign accept = req_v_o & req_ready_and_i;

  // after each accept, point at the channel that lost
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_r <= 1'b0;
    end else if (accept) begin
      rr_r <= ~grant_aw;
    end
  end

  // only one address channel may complete a handshake per cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(ar_ready_and_o && aw_ready_and_o));

endmodule

`default_nettype wire

// File: source/axi_burst_pump.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_pump (
  input  wire                                      clk_i
  , input  wire                                    reset_i

  // request from the arbiter
  , input  wire                                    v_i
  , output logic                                   ready_and_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0] addr_i
  , input  axi_burst_pkg::axi_burst_e               burst_i
  , input  wire [7:0]                              len_i
  , input  wire [2:0]                              size_i
  , input  wire                                    write_i

  // one beat per transfer toward the beat port
  , output logic                                   v_o
  , input  wire                                    send_i
  , output logic [axi_burst_pkg::addr_width_lp-1:0] addr_o
  , output logic [axi_burst_pkg::mask_width_lp-1:0] mask_o
  , output logic                                   first_o
  , output logic                                   last_o
  , output logic                                   write_o
  );

  import axi_burst_pkg::*;

  logic accept, send, send_last;

  // fsm state is low while waiting for a request and high while sending beats
  logic sending_r, sending_n;

  // captured request
  logic [addr_width_lp-1:0] addr_r, addr_n;
  axi_burst_e               burst_r;
  logic [7:0]               len_r;
  logic [2:0]               size_r;
  logic                     write_r;

  // number of transfers already sent in this burst
  logic [7:0] count_r;

  logic [7:0]               nbytes;
  logic [addr_width_lp-1:0] aligned_addr, aligned_incr;
  logic [2:0]               lg_len;
  logic [3:0]               wrap_shift;
  logic [addr_width_lp-1:0] wrap_bytes, lower_wrap, upper_wrap;
  logic                     do_wrap;

  logic [addr_width_lp-1:0]    mask_addr, upper_span;
  logic [lg_mask_width_lp-1:0] lower_lane, upper_lane;
  logic [lg_mask_width_lp:0]   upper_lane_p1;
  logic [mask_width_lp-1:0]    lo_ones, hi_ones;

  assign accept    = v_i & ready_and_o;
  assign send      = v_o & send_i;
  assign send_last = send & last_o;

  // bytes per transfer
  assign nbytes = 8'd1 << size_r;

  // current address rounded down to the transfer size
  assign aligned_addr = (addr_r >> size_r) << size_r;
  assign aligned_incr = aligned_addr + addr_width_lp'(nbytes);

  // wrap length is a power of two, so log2 comes from a small table
  always_comb begin
    case (len_r)
      8'd1:    lg_len = 3'd1;
      8'd3:    lg_len = 3'd2;
      8'd7:    lg_len = 3'd3;
      8'd15:   lg_len = 3'd4;
      default: lg_len = 3'd0;
    endcase
  end

  // wrap window is (len+1) * nbytes bytes wide
  assign wrap_shift = {1'b0, lg_len} + {1'b0, size_r};
  assign wrap_bytes = (addr_width_lp'(len_r) + addr_width_lp'(1)) << size_r;

  // running address stays inside the window, so its boundary matches the start
  assign lower_wrap = (addr_r >> wrap_shift) << wrap_shift;
  assign upper_wrap = lower_wrap + wrap_bytes;
  assign do_wrap    = (aligned_incr >= upper_wrap);

  // lower byte lane is the address offset inside the word
  assign mask_addr  = (addr_r >> lg_mask_width_lp) << lg_mask_width_lp;
  assign lower_lane = addr_r[lg_mask_width_lp-1:0];
  // upper lane ends at the next size boundary
  // also right for an aligned address, where it is lower + nbytes - 1
  assign upper_span = aligned_incr - mask_addr - addr_width_lp'(1);
  assign upper_lane = upper_span[lg_mask_width_lp-1:0];
  assign upper_lane_p1 = {1'b0, upper_lane} + 1'b1;

  // ones from the lower lane upward and cleared above the upper lane
  assign lo_ones = {mask_width_lp{1'b1}} << lower_lane;
  assign hi_ones = {mask_width_lp{1'b1}} << upper_lane_p1;
  assign mask_o  = lo_ones & ~hi_ones;

  assign addr_o  = addr_r;
  assign first_o = (count_r == 8'd0);
  assign last_o  = (count_r == len_r);
  assign write_o = write_r;
  assign v_o     = sending_r;
  assign ready_and_o = ~sending_r;

  always_comb begin
    sending_n = sending_r;
    if (!sending_r && accept) begin
      sending_n = 1'b1;
    end else if (sending_r && send_last) begin
      sending_n = 1'b0;
    end
  end

  // next beat address
  always_comb begin
    case (burst_r)
      // start again at aligned address plus one transfer
      e_incr:  addr_n = aligned_incr;
      // like incr but folds back at the upper boundary
      e_wrap:  addr_n = do_wrap ? lower_wrap : aligned_incr;
      // fixed keeps the start address
      default: addr_n = addr_r;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sending_r <= 1'b0;
      count_r   <= 8'd0;
    end else begin
      sending_r <= sending_n;
      if (accept) begin
        count_r <= 8'd0;
      end else if (send) begin
        count_r <= count_r + 8'd1;
      end
    end
  end

  // request fields and running address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_r  <= addr_i;
      burst_r <= burst_i;
      len_r   <= len_i;
      size_r  <= size_i;
      write_r <= write_i;
    end else if (send) begin
      addr_r <= addr_n;
    end
  end

  // wrap needs len 2/4/8/16 and a start aligned to the size
  assert property (@(posedge clk_i) disable iff (reset_i)
    (accept && burst_i == e_wrap) |->
      ((len_i inside {8'd1, 8'd3, 8'd7, 8'd15})
       && (((addr_i >> size_i) << size_i) == addr_i)));

  // transfer no wider than the bus
  assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (size_i <= 3'(max_size_lp)));

  // reserved burst encoding never reaches the pump
  assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> (burst_i != e_reserved));

endmodule

`default_nettype wire

// File: source/mem_beat_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_beat_port (
  input  wire                                        clk_i
  , input  wire                                      reset_i

  // beat from the pump
  , input  wire                                      beat_v_i
  , output logic                                     beat_send_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0]   beat_addr_i
  , input  wire [axi_burst_pkg::mask_width_lp-1:0]   beat_mask_i
  , input  wire                                      beat_last_i
  , input  wire                                      beat_write_i

  // memory side
  , output logic                                     mem_v_o
  , input  wire                                      mem_ready_i
  , output logic [axi_burst_pkg::word_addr_width_lp-1:0] mem_word_addr_o
  , output logic [axi_burst_pkg::mask_width_lp-1:0]  mem_strb_o
  , output logic                                     mem_write_o
  , output logic                                     mem_last_o
  );

  import axi_burst_pkg::*;

  logic load;

  // register can take a beat when empty or when the held one drains
  assign beat_send_o = ~mem_v_o | mem_ready_i;
  assign load = beat_v_i & beat_send_o;

  // occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_v_o <= 1'b0;
    end else if (beat_send_o) begin
      mem_v_o <= beat_v_i;
    end
  end

  // beat payload, byte offset dropped from the address
  always_ff @(posedge clk_i) begin
    if (load) begin
      mem_word_addr_o <= beat_addr_i[addr_width_lp-1:lg_mask_width_lp];
      mem_strb_o      <= beat_mask_i;
      mem_write_o     <= beat_write_i;
      mem_last_o      <= beat_last_i;
    end
  end

  // a stalled access keeps every field until memory takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_v_o && !mem_ready_i) |=>
      (mem_v_o && $stable(mem_word_addr_o) && $stable(mem_strb_o)
       && $stable(mem_write_o) && $stable(mem_last_o)));

endmodule

`default_nettype wire

// File: source/axi_burst_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_top (
  input  wire                                      clk_i
  , input  wire                                    reset_i

  , input  wire                                    ar_v_i
  , output logic                                   ar_ready_and_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0] ar_addr_i
  , input  axi_burst_pkg::axi_burst_e               ar_burst_i
  , input  wire [7:0]                              ar_len_i
  , input  wire [2:0]                              ar_size_i

  , input  wire                                    aw_v_i
  , output logic                                   aw_ready_and_o
  , input  wire [axi_burst_pkg::addr_width_lp-1:0] aw_addr_i
  , input  axi_burst_pkg::axi_burst_e               aw_burst_i
  , input  wire [7:0]                              aw_len_i
  , input  wire [2:0]                              aw_size_i

  , output logic                                   mem_v_o
  , input  wire                                    mem_ready_i
  , output logic [axi_burst_pkg::word_addr_width_lp-1:0] mem_word_addr_o
  , output logic [axi_burst_pkg::mask_width_lp-1:0] mem_strb_o
  , output logic                                   mem_write_o
  , output logic                                   mem_last_o
  );

  import axi_burst_pkg::*;

  // arbiter to pump
  logic                     req_v, req_ready_and, req_write;
  logic [addr_width_lp-1:0] req_addr;
  axi_burst_e               req_burst;
  logic [7:0]               req_len;
  logic [2:0]               req_size;

  // pump to beat register
  logic                     beat_v, beat_send, beat_last, beat_write;
  logic [addr_width_lp-1:0] beat_addr;
  logic [mask_width_lp-1:0] beat_mask;

  axi_ax_arbiter arb (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.ar_v_i(ar_v_i), .ar_ready_and_o(ar_ready_and_o), .ar_addr_i(ar_addr_i)
    ,.ar_burst_i(ar_burst_i), .ar_len_i(ar_len_i), .ar_size_i(ar_size_i)
    ,.aw_v_i(aw_v_i), .aw_ready_and_o(aw_ready_and_o), .aw_addr_i(aw_addr_i)
    ,.aw_burst_i(aw_burst_i), .aw_len_i(aw_len_i), .aw_size_i(aw_size_i)
    ,.req_v_o(req_v), .req_ready_and_i(req_ready_and), .req_addr_o(req_addr)
    ,.req_burst_o(req_burst), .req_len_o(req_len), .req_size_o(req_size)
    ,.req_write_o(req_write)
  );

  // first flag is not needed on the memory port
  axi_burst_pump pump (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(req_v), .ready_and_o(req_ready_and), .addr_i(req_addr)
    ,.burst_i(req_burst), .len_i(req_len), .size_i(req_size), .write_i(req_write)
    ,.v_o(beat_v), .send_i(beat_send), .addr_o(beat_addr), .mask_o(beat_mask)
    ,.first_o(), .last_o(beat_last), .write_o(beat_write)
  );

  mem_beat_port port (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.beat_v_i(beat_v), .beat_send_o(beat_send), .beat_addr_i(beat_addr)
    ,.beat_mask_i(beat_mask), .beat_last_i(beat_last), .beat_write_i(beat_write)
    ,.mem_v_o(mem_v_o), .mem_ready_i(mem_ready_i), .mem_word_addr_o(mem_word_addr_o)
    ,.mem_strb_o(mem_strb_o), .mem_write_o(mem_write_o), .mem_last_o(mem_last_o)
  );

endmodule

`default_nettype wire

// File: verification/axi_burst_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_tb;

  import axi_burst_pkg::*;

  // one table row, ch 0 read, 1 write, 2 both channels with two requests each
  typedef struct packed {
    logic [1:0]               ch;
    logic [addr_width_lp-1:0] addr;
    axi_burst_e               burst;
    logic [7:0]               len;
    logic [2:0]               size;
    logic                     stall;
  } row_t;

  // expected memory-port access
  typedef struct packed {
    logic [word_addr_width_lp-1:0] word_addr;
    logic [mask_width_lp-1:0]      strb;
    logic                          write;
    logic                          last;
  } beat_t;

  logic clk_i, reset_i, mem_ready_i;
  logic ar_v_i, aw_v_i, ar_ready_and_o, aw_ready_and_o;
  logic [addr_width_lp-1:0] ar_addr_i, aw_addr_i;
  axi_burst_e ar_burst_i, aw_burst_i;
  logic [7:0] ar_len_i, aw_len_i;
  logic [2:0] ar_size_i, aw_size_i;
  logic mem_v_o, mem_write_o, mem_last_o;
  logic [word_addr_width_lp-1:0] mem_word_addr_o;
  logic [mask_width_lp-1:0] mem_strb_o;

  row_t rows [12] = '{
    '{2'd0, 32'h0000_1006, e_fixed, 8'd3,  3'd1, 1'b0},
    '{2'd1, 32'h0000_2005, e_incr,  8'd4,  3'd3, 1'b0},
    '{2'd0, 32'h0000_3001, e_incr,  8'd7,  3'd1, 1'b0},
    '{2'd1, 32'h0000_4004, e_wrap,  8'd1,  3'd2, 1'b0},
    '{2'd0, 32'h0000_5018, e_wrap,  8'd3,  3'd3, 1'b0},
    '{2'd1, 32'h0000_600a, e_wrap,  8'd7,  3'd1, 1'b0},
    '{2'd0, 32'h0000_7034, e_wrap,  8'd15, 3'd2, 1'b0},
    '{2'd2, 32'h0000_8000, e_incr,  8'd3,  3'd3, 1'b0},
    '{2'd1, 32'h0000_9003, e_incr,  8'd15, 3'd2, 1'b1},
    '{2'd0, 32'h0000_a010, e_wrap,  8'd7,  3'd3, 1'b1},
    '{2'd2, 32'h0000_b006, e_incr,  8'd2,  3'd1, 1'b1},
    '{2'd1, 32'h0000_c005, e_fixed, 8'd5,  3'd2, 1'b1}
  };

  string names [12] = '{
    "fixed read", "incr full unaligned", "incr narrow unaligned", "wrap2",
    "wrap4", "wrap8", "wrap16", "both channels", "incr stalled", "wrap stalled",
    "both stalled", "fixed stalled"
  };

  beat_t exp_q [$];
  row_t  ar_q [$];
  row_t  aw_q [$];
  int    errors, test_errors, beats_seen;

  axi_burst_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // expand one request into its beats by the AXI transfer rules
  task automatic expand(input row_t r, input logic write);
    logic [31:0] nbytes, total, aligned, boundary, addr_n, lower, upper;
    int n, l;
    beat_t b;
    nbytes   = 32'd1 << r.size;
    total    = nbytes * (r.len + 32'd1);
    aligned  = (r.addr / nbytes) * nbytes;
    boundary = (r.addr / total) * total;
    for (n = 1; n <= r.len + 1; n++) begin
      // transfer n of the burst
      addr_n = aligned + (n - 1) * nbytes;
      if (r.burst == e_fixed || n == 1) begin
        addr_n = r.addr;
      end else if (r.burst == e_wrap && addr_n >= boundary + total) begin
        addr_n = addr_n - total;
      end
      // lanes from the byte address up to the end of the aligned transfer
      lower = addr_n - (addr_n / mask_width_lp) * mask_width_lp;
      upper = (addr_n / nbytes) * nbytes + nbytes - 1 - (addr_n / mask_width_lp) * mask_width_lp;
      for (l = 0; l < mask_width_lp; l++) begin
        b.strb[l] = (l >= lower) && (l <= upper);
      end
      b.word_addr = addr_n[addr_width_lp-1:lg_mask_width_lp];
      b.write     = write;
      b.last      = (n == r.len + 1);
      exp_q.push_back(b);
    end
  endtask

  task automatic check_word(input string name, input logic [word_addr_width_lp-1:0] got,
                            input logic [word_addr_width_lp-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_strb(input string name, input logic [mask_width_lp-1:0] got,
                            input logic [mask_width_lp-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  // called at a rising edge, reset stays high over three edges
  task automatic apply_reset();
    reset_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  // present the head of each channel queue, draw the memory stall
  task automatic drive(input logic stall);
    ar_v_i <= (ar_q.size() > 0);
    aw_v_i <= (aw_q.size() > 0);
    if (ar_q.size() > 0) begin
      ar_addr_i  <= ar_q[0].addr;
      ar_burst_i <= ar_q[0].burst;
      ar_len_i   <= ar_q[0].len;
      ar_size_i  <= ar_q[0].size;
    end
    if (aw_q.size() > 0) begin
      aw_addr_i  <= aw_q[0].addr;
      aw_burst_i <= aw_q[0].burst;
      aw_len_i   <= aw_q[0].len;
      aw_size_i  <= aw_q[0].size;
    end
    mem_ready_i <= stall ? ($urandom % 4 != 0) : 1'b1;
  endtask

  // an access completed on the memory port
  task automatic take_beat();
    beat_t b;
    if (exp_q.size() == 0) begin
      $display("extra beat on the memory port at word address %h", mem_word_addr_o);
      test_errors++;
    end else begin
      b = exp_q.pop_front();
      check_word("mem_word_addr_o", mem_word_addr_o, b.word_addr);
      check_strb("mem_strb_o", mem_strb_o, b.strb);
      check_flag("mem_write_o", mem_write_o, b.write);
      check_flag("mem_last_o", mem_last_o, b.last);
      beats_seen++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r, r2;
    int k, limit, cycles, total_beats;
    r = rows[idx];
    test_errors = 0;
    ar_q.delete();
    aw_q.delete();
    exp_q.delete();
    // both-channel rows start from reset so the pointer favours read
    if (r.ch == 2'd2) begin
      apply_reset();
      for (k = 0; k < 2; k++) begin
        r2 = r;
        r2.addr = r.addr + k * 32'h200;
        ar_q.push_back(r2);
        expand(r2, 1'b0);
        r2.addr = r.addr + k * 32'h200 + 32'h100;
        aw_q.push_back(r2);
        expand(r2, 1'b1);
      end
    end else if (r.ch == 2'd0) begin
      ar_q.push_back(r);
      expand(r, 1'b0);
    end else begin
      aw_q.push_back(r);
      expand(r, 1'b1);
    end
    total_beats = exp_q.size();
    limit = total_beats * 4 + 40;
    cycles = 0;
    drive(r.stall);
    while ((exp_q.size() > 0 || ar_q.size() > 0 || aw_q.size() > 0) && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
      if (ar_v_i && ar_ready_and_o) begin
        void'(ar_q.pop_front());
      end
      if (aw_v_i && aw_ready_and_o) begin
        void'(aw_q.pop_front());
      end
      if (mem_v_o && mem_ready_i) begin
        take_beat();
      end
      drive(r.stall);
    end
    if (exp_q.size() > 0 || ar_q.size() > 0 || aw_q.size() > 0) begin
      $display("test %0d: %0d beats never reached the memory port", idx, exp_q.size());
      test_errors++;
      ar_q.delete();
      aw_q.delete();
      exp_q.delete();
    end
    // quiet window, anything arriving now is surplus
    ar_v_i <= 1'b0;
    aw_v_i <= 1'b0;
    mem_ready_i <= 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      if (mem_v_o && mem_ready_i) begin
        take_beat();
      end
    end
    $display("test %0d %s: %0d beats, %0d errors", idx, names[idx], total_beats, test_errors);
    errors += test_errors;
  endtask

  initial begin : main
    int i;
    void'($urandom(76));
    errors = 0;
    beats_seen = 0;
    reset_i = 1'b1;
    mem_ready_i = 1'b0;
    ar_v_i = 1'b0;
    ar_addr_i = '0;
    ar_burst_i = e_fixed;
    ar_len_i = 8'd0;
    ar_size_i = 3'd0;
    aw_v_i = 1'b0;
    aw_addr_i = '0;
    aw_burst_i = e_fixed;
    aw_len_i = 8'd0;
    aw_size_i = 3'd0;
    apply_reset();
    for (i = 0; i < $size(rows); i++) begin
      run_row(i);
    end
    $display("tests %0d, beats %0d, errors %0d", $size(rows), beats_seen, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // budget of four cycles per beat plus a fixed allowance per row
  initial begin : watchdog
    int unsigned budget;
    budget = 1000;
    foreach (rows[k]) begin
      budget += ((rows[k].ch == 2'd2 ? 4 : 1) * (rows[k].len + 1) * 4 + 60) * 10;
    end
    #(budget);
    $display("run did not finish within %0d ns", budget);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_burst_top.f
source/axi_burst_pkg.sv
source/axi_ax_arbiter.sv
source/axi_burst_pump.sv
source/mem_beat_port.sv
source/axi_burst_top.sv
verification/axi_burst_tb.sv

// File: Makefile
# Verilator flow for the AXI burst expander

TOP = axi_burst_tb

.PHONY: lint sim clean

# lint the RTL top level on its own, then the full testbench build
lint:
	verilator --lint-only --assert source/axi_burst_pkg.sv source/axi_ax_arbiter.sv \
		source/axi_burst_pump.sv source/mem_beat_port.sv source/axi_burst_top.sv \
		--top-module axi_burst_top
	verilator --lint-only --timing --assert -f axi_burst_top.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f axi_burst_top.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
